// ==== common/core_consts.svh ====
/* Width, register count, opcode and funct code macros for the integer pipeline */

`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Data path word width
`define CORE_XLEN 32

// Architectural register file size and the index width that addresses it
`define CORE_NUM_REGS 32
`define CORE_REG_IDX_W 5

// Major opcodes accepted by decode, register-register and register-immediate
`define OPC_OP 7'b0110011
`define OPC_OP_IMM 7'b0010011

// The funct3 codes of the supported subset
// ADD also covers SUB and ADDI, and SLT also covers SLTI
`define F3_ADD 3'b000
`define F3_SLT 3'b010
`define F3_XOR 3'b100
`define F3_OR 3'b110
`define F3_AND 3'b111

// Setting bit 30 of an OP instruction with funct3 ADD selects SUB
`define F7_SUB 7'b0100000

`endif

// ==== common/core_pkg.sv ====
/* Shared vector types and ALU operation codes of the integer pipeline */

`default_nettype none

`include "core_consts.svh"

package core_pkg;

  // One data value as held in the register file and produced by the ALU
  typedef logic [`CORE_XLEN-1:0] word_t;

  // Raw instruction word, always 32 bits in this ISA
  typedef logic [31:0] instr_t;

  // Architectural register index
  typedef logic [`CORE_REG_IDX_W-1:0] reg_idx_t;

  // ALU operation selected by decode
  typedef logic [2:0] alu_op_t;

  // Encodings of alu_op_t
  // These are internal to the pipeline and unrelated to funct3
  localparam alu_op_t ALU_ADD = 3'd0;
  localparam alu_op_t ALU_SUB = 3'd1;
  localparam alu_op_t ALU_AND = 3'd2;
  localparam alu_op_t ALU_OR = 3'd3;
  localparam alu_op_t ALU_XOR = 3'd4;
  // Signed compare, result is 1 or 0
  localparam alu_op_t ALU_SLT = 3'd5;

endpackage

`default_nettype wire

// ==== common/decode_if.sv ====
/* Decode-to-execute bundle that carries one cracked instruction and its operands */

`timescale 1ns/1ps
`default_nettype none

interface decode_if
  import core_pkg::*;
();

  // An instruction sits in the execute input register
  logic valid;
  // Operation for the ALU
  alu_op_t alu_op;
  // Destination index and whether it is written at all
  reg_idx_t rd;
  logic rd_write;
  // Source indices, kept so execute can match them against its own result
  reg_idx_t rs1;
  reg_idx_t rs2;
  // Operand values as read from the register file during decode
  word_t src_a;
  word_t src_b;
  // Second operand comes from the immediate instead of src_b
  logic use_imm;
  word_t imm;

  // Decode loads every field in its pipeline register
  modport producer (
    output valid, alu_op, rd, rd_write,
    output rs1, rs2, src_a, src_b,
    output use_imm, imm
  );

  // Execute only reads the bundle
  modport consumer (
    input valid, alu_op, rd, rd_write,
    input rs1, rs2, src_a, src_b,
    input use_imm, imm
  );

endinterface

`default_nettype wire

// ==== pipeline/register_file.sv ====
/* 32 x 32 register file with hardwired x0, two read ports and write-through bypass */

`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module register_file
  import core_pkg::*;
(
  input wire logic clk,
  input wire logic reset,
  input wire logic we,
  input wire reg_idx_t waddr,
  input wire word_t wdata,
  input wire reg_idx_t raddr_a,
  input wire reg_idx_t raddr_b,
  output word_t rdata_a,
  output word_t rdata_b
);

  word_t regs [`CORE_NUM_REGS];

  // A read of the register being written this cycle sees the new value
  // The x0 check keeps a stray write to x0 from leaking through the bypass
  logic hit_a;
  logic hit_b;

  // Reset clears every entry, entry 0 is never stored to afterwards
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < `CORE_NUM_REGS; i++)
        regs[i] <= '0;
    end
    else if (we && (waddr != '0))
    begin
      regs[waddr] <= wdata;
    end
  end

  assign hit_a = we && (waddr == raddr_a) && (raddr_a != '0);
  assign hit_b = we && (waddr == raddr_b) && (raddr_b != '0);

  // Both read ports are combinational
  assign rdata_a = hit_a ? wdata : regs[raddr_a];
  assign rdata_b = hit_b ? wdata : regs[raddr_b];

endmodule

`default_nettype wire

// ==== pipeline/decode_stage.sv ====
/* Decode stage: instruction cracking, operand read and the decode pipeline register */

`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module decode_stage
  import core_pkg::*;
(
  input wire logic clk,
  input wire logic reset,
  input wire logic instr_valid,
  input wire instr_t instr,
  input wire word_t rdata_a,
  input wire word_t rdata_b,
  output reg_idx_t raddr_a,
  output reg_idx_t raddr_b,
  decode_if.producer dec
);

  // Instruction fields, standard RV32 positions
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t rd;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t imm_i;

  // Result of cracking
  logic legal;
  alu_op_t alu_op;
  logic use_imm;

  assign opcode = instr[6:0];
  assign rd = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];
  assign funct7 = instr[31:25];

  // I-type immediate, sign bit is instr[31]
  assign imm_i = {{(`CORE_XLEN-12){instr[31]}}, instr[31:20]};

  // Register file is read straight from the incoming instruction
  // For immediate forms rs2 is part of the immediate and the read is just unused
  assign raddr_a = rs1;
  assign raddr_b = rs2;

  always_comb
  begin
    legal = 1'b0;
    alu_op = ALU_ADD;
    use_imm = 1'b0;
    case (opcode)
      `OPC_OP:
      begin
        // Register forms need funct7 zero, except SUB
        case (funct3)
          `F3_ADD:
          begin
            legal = (funct7 == 7'b0) || (funct7 == `F7_SUB);
            alu_op = (funct7 == `F7_SUB) ? ALU_SUB : ALU_ADD;
          end
          `F3_SLT: {legal, alu_op} = {funct7 == 7'b0, ALU_SLT};
          `F3_XOR: {legal, alu_op} = {funct7 == 7'b0, ALU_XOR};
          `F3_OR: {legal, alu_op} = {funct7 == 7'b0, ALU_OR};
          `F3_AND: {legal, alu_op} = {funct7 == 7'b0, ALU_AND};
          default: legal = 1'b0;
        endcase
      end
      `OPC_OP_IMM:
      begin
        // Shifts and SLTIU fall through to the default and stay illegal
        use_imm = 1'b1;
        case (funct3)
          `F3_ADD: {legal, alu_op} = {1'b1, ALU_ADD};
          `F3_SLT: {legal, alu_op} = {1'b1, ALU_SLT};
          `F3_XOR: {legal, alu_op} = {1'b1, ALU_XOR};
          `F3_OR: {legal, alu_op} = {1'b1, ALU_OR};
          `F3_AND: {legal, alu_op} = {1'b1, ALU_AND};
          default: legal = 1'b0;
        endcase
      end
      default: legal = 1'b0;
    endcase
  end

  // Control half of the pipeline register
  // An illegal encoding or rd of x0 leaves a bubble that never writes
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      dec.valid <= 1'b0;
      dec.rd_write <= 1'b0;
    end
    else
    begin
      dec.valid <= instr_valid;
      dec.rd_write <= instr_valid && legal && (rd != '0);
    end
  end

  // Payload half, loaded on every edge
  always_ff @(posedge clk)
  begin
    dec.alu_op <= alu_op;
    dec.rd <= rd;
    dec.rs1 <= rs1;
    dec.rs2 <= rs2;
    dec.src_a <= rdata_a;
    dec.src_b <= rdata_b;
    dec.use_imm <= use_imm;
    dec.imm <= imm_i;
  end

endmodule

`default_nettype wire

// ==== pipeline/execute_stage.sv ====
/* Execute stage: result forwarding, ALU and the writeback pipeline register */

`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module execute_stage
  import core_pkg::*;
(
  input wire logic clk,
  input wire logic reset,
  decode_if.consumer dec,
  output logic wb_valid,
  output reg_idx_t wb_rd,
  output word_t wb_data
);

  // Forwarding matches, the previous instruction's result is still in wb_data
  logic fwd_a;
  logic fwd_b;

  // Operands after forwarding and the immediate select
  word_t op_a;
  word_t op_b_reg;
  word_t op_b;

  // Signed compare for SLT and SLTI
  logic less_than;

  word_t result;

  // wb_valid is never high for x0, so rs of zero cannot match here
  assign fwd_a = wb_valid && (wb_rd == dec.rs1);
  assign fwd_b = wb_valid && (wb_rd == dec.rs2);

  assign op_a = fwd_a ? wb_data : dec.src_a;
  assign op_b_reg = fwd_b ? wb_data : dec.src_b;

  // Immediate forms take the sign-extended immediate as second operand
  assign op_b = dec.use_imm ? dec.imm : op_b_reg;

  assign less_than = $signed(op_a) < $signed(op_b);

  always_comb
  begin
    case (dec.alu_op)
      ALU_ADD: result = op_a + op_b;
      ALU_SUB: result = op_a - op_b;
      ALU_AND: result = op_a & op_b;
      ALU_OR: result = op_a | op_b;
      ALU_XOR: result = op_a ^ op_b;
      ALU_SLT: result = {{(`CORE_XLEN-1){1'b0}}, less_than};
      // Decode never issues another code
      default: result = '0;
    endcase
  end

  // Only a valid instruction that writes a register makes a writeback pulse
  always_ff @(posedge clk)
  begin
    if (reset)
      wb_valid <= 1'b0;
    else
      wb_valid <= dec.valid && dec.rd_write;
  end

  // Writeback payload
  always_ff @(posedge clk)
  begin
    wb_rd <= dec.rd;
    wb_data <= result;
  end

endmodule

`default_nettype wire

// ==== source/int_pipeline_top.sv ====
/* Integer pipeline top level: decode, execute and register file wired together */

`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module int_pipeline_top
  import core_pkg::*;
(
  input wire logic clk,
  input wire logic reset,
  // One instruction per strobe, the pipeline never stalls
  input wire logic instr_valid,
  input wire logic [31:0] instr,
  // Writeback port, two rising edges after the instruction is sampled
  output logic wb_valid,
  output logic [`CORE_REG_IDX_W-1:0] wb_rd,
  output logic [`CORE_XLEN-1:0] wb_data
);

  // Decode side of the register file
  reg_idx_t raddr_a;
  reg_idx_t raddr_b;
  word_t rdata_a;
  word_t rdata_b;

  // Cracked instruction between decode and execute
  decode_if dec_bus ();

  // Decode reads operands in the same cycle the instruction arrives
  decode_stage u_decode (
    .clk (clk),
    .reset (reset),
    .instr_valid (instr_valid),
    .instr (instr),
    .rdata_a (rdata_a),
    .rdata_b (rdata_b),
    .raddr_a (raddr_a),
    .raddr_b (raddr_b),
    .dec (dec_bus.producer)
  );

  // Execute forwards its own last result and registers the new one
  execute_stage u_execute (
    .clk (clk),
    .reset (reset),
    .dec (dec_bus.consumer),
    .wb_valid (wb_valid),
    .wb_rd (wb_rd),
    .wb_data (wb_data)
  );

  // The writeback outputs double as the register file write port
  // Its write-through bypass covers a reader two instructions behind
  register_file u_regfile (
    .clk (clk),
    .reset (reset),
    .we (wb_valid),
    .waddr (wb_rd),
    .wdata (wb_data),
    .raddr_a (raddr_a),
    .raddr_b (raddr_b),
    .rdata_a (rdata_a),
    .rdata_b (rdata_b)
  );

endmodule

`default_nettype wire

// ==== tests/int_pipeline_asserts.sv ====
/* Concurrent assertions on writeback timing and writeback rules, bound to the pipeline top */

`timescale 1ns/1ps
`default_nettype none

module int_pipeline_asserts (
  input wire logic clk,
  input wire logic reset,
  input wire logic instr_valid,
  input wire logic dec_valid,
  input wire logic dec_rd_write,
  input wire logic wb_valid,
  input wire logic [4:0] wb_rd
);

  // Number of failed assertions, a nonzero count ends the run
  int error_count;

  initial
    error_count = 0;

  // Execute comes out of reset idle
  wb_idle_after_reset: assert property (@(posedge clk) reset |=> !wb_valid)
  else
  begin
    error_count++;
    $error("wb_valid high in the cycle after reset");
  end

  // Decode has already turned writes to x0 into bubbles
  wb_never_x0: assert property (@(posedge clk) disable iff (reset) wb_valid |-> wb_rd != 5'd0)
  else
  begin
    error_count++;
    $error("writeback addressed to x0");
  end

  // A writing instruction in the execute input register leaves one edge later
  wb_follows_decode: assert property (@(posedge clk) disable iff (reset)
    dec_valid && dec_rd_write |=> wb_valid)
  else
  begin
    error_count++;
    $error("writing instruction in execute produced no writeback");
  end

  // Latency from the instruction strobe to the writeback is two rising edges
  wb_has_source: assert property (@(posedge clk) disable iff (reset)
    wb_valid |-> $past(instr_valid, 2))
  else
  begin
    error_count++;
    $error("writeback without an instruction two edges earlier");
  end

endmodule

bind int_pipeline_top int_pipeline_asserts u_asserts (
  .clk (clk),
  .reset (reset),
  .instr_valid (instr_valid),
  .dec_valid (dec_bus.valid),
  .dec_rd_write (dec_bus.rd_write),
  .wb_valid (wb_valid),
  .wb_rd (wb_rd)
);

`default_nettype wire

// ==== tests/int_pipeline_tb.sv ====
/* Integer pipeline testbench with clock, reset, random program stimulus,
   reference register model and writeback checking */

`timescale 1ns/1ps
`default_nettype none

`include "core_consts.svh"

module int_pipeline_tb;

  localparam int CLK_PERIOD = 4;
  localparam int RESET_CYCLES = 10;
  localparam logic [31:0] SEED = 32'he9b3;
  // Cycles allowed for the last writebacks to come out
  localparam int DRAIN_TIMEOUT = 20;
  // Hard limit on the whole run in clock cycles
  localparam int RUN_TIMEOUT = 20000;

  logic clk;
  logic reset;
  logic instr_valid;
  logic [31:0] instr;
  logic wb_valid;
  logic [4:0] wb_rd;
  logic [31:0] wb_data;

  // Architectural state as the program has left it so far
  logic [31:0] ref_regs [32];
  // Expected writebacks in program order
  logic [4:0] exp_rd [$];
  logic [31:0] exp_data [$];

  logic [4:0] chk_rd;
  logic [31:0] chk_data;
  int drain_cycles;
  int step;
  logic [4:0] dest;
  logic [4:0] prev_rd;
  logic [4:0] prev2_rd;

  int_pipeline_top uut (
    .clk (clk),
    .reset (reset),
    .instr_valid (instr_valid),
    .instr (instr),
    .wb_valid (wb_valid),
    .wb_rd (wb_rd),
    .wb_data (wb_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  // R-type and I-type encoders of the standard RV32 layout
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `OPC_OP};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, `OPC_OP_IMM};
  endfunction

  // Subset membership straight from the ISA tables
  function automatic logic is_legal(input logic [31:0] w);
    logic [2:0] f3;
    logic [6:0] f7;
    logic ok;
    f3 = w[14:12];
    f7 = w[31:25];
    ok = 1'b0;
    if (w[6:0] == `OPC_OP)
    begin
      if (f3 == `F3_ADD)
        ok = (f7 == 7'd0) || (f7 == `F7_SUB);
      else if (f3 == `F3_SLT || f3 == `F3_XOR || f3 == `F3_OR || f3 == `F3_AND)
        ok = (f7 == 7'd0);
    end
    else if (w[6:0] == `OPC_OP_IMM)
    begin
      ok = (f3 == `F3_ADD) || (f3 == `F3_SLT) || (f3 == `F3_XOR) || (f3 == `F3_OR)
        || (f3 == `F3_AND);
    end
    return ok;
  endfunction

  function automatic logic [31:0] expected_result(input logic [31:0] w,
      input logic [31:0] a, input logic [31:0] rs2_val);
    logic [31:0] b;
    logic [31:0] r;
    // Immediate forms use the sign-extended I immediate
    b = (w[6:0] == `OPC_OP_IMM) ? {{20{w[31]}}, w[31:20]} : rs2_val;
    case (w[14:12])
      `F3_ADD: r = (w[6:0] == `OPC_OP && w[31:25] == `F7_SUB) ? a - b : a + b;
      `F3_SLT: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      `F3_XOR: r = a ^ b;
      `F3_OR: r = a | b;
      `F3_AND: r = a & b;
      default: r = 32'd0;
    endcase
    return r;
  endfunction

  // Executes one instruction on the model in program order
  function automatic void model_step(input logic [31:0] w);
    logic [4:0] rd;
    logic [31:0] r;
    rd = w[11:7];
    if (is_legal(w) && rd != 5'd0)
    begin
      r = expected_result(w, ref_regs[w[19:15]], ref_regs[w[24:20]]);
      ref_regs[rd] = r;
      exp_rd.push_back(rd);
      exp_data.push_back(r);
    end
  endfunction

  // One of the eleven supported operations with random immediate
  function automatic logic [31:0] legal_instr(input logic [4:0] rd, input logic [4:0] rs1,
      input logic [4:0] rs2);
    logic [11:0] imm;
    logic [31:0] w;
    imm = 12'($urandom());
    case ($urandom_range(0, 10))
      0: w = r_type(7'd0, rs2, rs1, `F3_ADD, rd);
      1: w = r_type(`F7_SUB, rs2, rs1, `F3_ADD, rd);
      2: w = r_type(7'd0, rs2, rs1, `F3_SLT, rd);
      3: w = r_type(7'd0, rs2, rs1, `F3_XOR, rd);
      4: w = r_type(7'd0, rs2, rs1, `F3_OR, rd);
      5: w = r_type(7'd0, rs2, rs1, `F3_AND, rd);
      6: w = i_type(imm, rs1, `F3_ADD, rd);
      7: w = i_type(imm, rs1, `F3_SLT, rd);
      8: w = i_type(imm, rs1, `F3_XOR, rd);
      9: w = i_type(imm, rs1, `F3_OR, rd);
      default: w = i_type(imm, rs1, `F3_AND, rd);
    endcase
    return w;
  endfunction

  // Encodings outside the subset come from any opcode, an M-extension funct7,
  // or shifts and SLTIU
  function automatic logic [31:0] junk_instr();
    logic [31:0] w;
    int kind;
    w = $urandom();
    kind = $urandom_range(0, 2);
    if (kind == 1)
    begin
      w[6:0] = `OPC_OP;
      w[31:25] = 7'b0000001;
    end
    else if (kind == 2)
    begin
      w[6:0] = `OPC_OP_IMM;
      w[14:12] = ($urandom_range(0, 1) == 0) ? 3'b001 : 3'b011;
    end
    return w;
  endfunction

  task automatic issue(input logic [31:0] w);
    @(negedge clk);
    instr_valid = 1'b1;
    instr = w;
    model_step(w);
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      @(negedge clk);
      instr_valid = 1'b0;
      // Noise on instr while the strobe is low must be ignored
      instr = $urandom();
    end
  endtask

  // Every writeback is matched against the front of the queue
  always @(posedge clk)
  begin
    if (!reset && wb_valid)
    begin
      if (exp_rd.size() == 0)
      begin
        $display("writeback to x%0d at %0t with no writing instruction in flight", wb_rd,
          $time);
        abort_run();
      end
      else
      begin
        chk_rd = exp_rd.pop_front();
        chk_data = exp_data.pop_front();
        assert (wb_rd == chk_rd && wb_data == chk_data)
        else
        begin
          $display("mismatch at %0t: wb x%0d = %h, expected x%0d = %h", $time, wb_rd,
            wb_data, chk_rd, chk_data);
          abort_run();
        end
      end
    end
  end

  always @(negedge clk)
  begin
    if (uut.u_asserts.error_count != 0)
    begin
      $display("a bound pipeline assertion failed before %0t", $time);
      abort_run();
    end
  end

  initial
  begin
    repeat (RUN_TIMEOUT) @(posedge clk);
    $display("run did not finish within %0d cycles", RUN_TIMEOUT);
    abort_run();
  end

  initial
  begin
    void'($urandom(SEED));
    reset = 1'b1;
    instr_valid = 1'b0;
    instr = 32'd0;
    for (int i = 0; i < 32; i++)
      ref_regs[i] = 32'd0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Add x0 to a cleared register and then read every register back as zero
    issue(r_type(7'd0, 5'd7, 5'd0, `F3_ADD, 5'd5));
    for (int i = 1; i < 32; i++)
      issue(r_type(7'd0, 5'd0, 5'(i), `F3_OR, 5'(i)));
    idle(3);

    // Writes to x0 are dropped and x0 still reads zero
    issue(i_type(12'd123, 5'd0, `F3_ADD, 5'd3));
    issue(i_type(12'h7ff, 5'd3, `F3_ADD, 5'd0));
    issue(r_type(7'd0, 5'd3, 5'd3, `F3_ADD, 5'd0));
    issue(r_type(7'd0, 5'd0, 5'd0, `F3_OR, 5'd4));
    issue(i_type(12'hfff, 5'd0, `F3_XOR, 5'd6));
    idle(2);

    // Random mix of every operation with occasional gaps
    for (step = 0; step < 300; step++)
    begin
      issue(legal_instr(5'($urandom_range(0, 31)), 5'($urandom()), 5'($urandom())));
      if ($urandom_range(0, 7) == 0)
        idle($urandom_range(1, 2));
    end

    // A fixed chain at distance one comes first
    // Random chains at distance one and two follow it
    repeat (4)
      issue(i_type(12'hffd, 5'd10, `F3_ADD, 5'd10));
    prev_rd = 5'd10;
    prev2_rd = 5'd6;
    for (step = 0; step < 200; step++)
    begin
      dest = 5'($urandom_range(1, 31));
      if ($urandom_range(0, 1) == 0)
        issue(legal_instr(dest, prev_rd, prev2_rd));
      else
        issue(legal_instr(dest, prev2_rd, prev_rd));
      prev2_rd = prev_rd;
      prev_rd = dest;
    end

    // Illegal encodings interleaved with dependent legal ones
    for (step = 0; step < 150; step++)
    begin
      if ($urandom_range(0, 1) == 0)
        issue(junk_instr());
      else
        issue(legal_instr(5'($urandom_range(1, 31)), prev_rd, 5'($urandom())));
    end

    // Final read-back of the whole register file
    for (int i = 1; i < 32; i++)
      issue(r_type(7'd0, 5'd0, 5'(i), `F3_OR, 5'(i)));
    idle(1);

    drain_cycles = 0;
    while (exp_rd.size() != 0 && drain_cycles < DRAIN_TIMEOUT)
    begin
      @(negedge clk);
      drain_cycles++;
    end
    if (exp_rd.size() != 0)
    begin
      $display("%0d expected writebacks never arrived", exp_rd.size());
      abort_run();
    end
    else
    begin
      // A few quiet cycles catch any late stray writeback
      idle(3);
      if (uut.u_asserts.error_count != 0)
      begin
        $display("a bound pipeline assertion failed before %0t", $time);
        abort_run();
      end
      else
      begin
        $display("Simulation completed successfully");
        $finish;
      end
    end
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+common
common/core_pkg.sv
common/decode_if.sv
pipeline/register_file.sv
pipeline/decode_stage.sv
pipeline/execute_stage.sv
source/int_pipeline_top.sv
tests/int_pipeline_asserts.sv
tests/int_pipeline_tb.sv
